// File: trace_pkg.sv
`default_nettype none

package trace_pkg;

  //////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////

  localparam int unsigned xlen       = 32;
  localparam int unsigned reg_addr_w = 5;
  localparam int unsigned cycle_w    = 32;
  localparam int unsigned opc_w      = 7;
  localparam int unsigned funct3_w   = 3;

  typedef logic [xlen-1:0]       data_t;
  typedef logic [reg_addr_w-1:0] reg_addr_t;
  typedef logic [cycle_w-1:0]    cycle_t;

  // instruction field positions, lsb of each field
  localparam int unsigned opcode_lsb = 0;
  localparam int unsigned rd_lsb     = 7;
  localparam int unsigned funct3_lsb = 12;
  localparam int unsigned rs1_lsb    = 15;
  localparam int unsigned rs2_lsb    = 20;

  // RV32I major opcodes
  localparam logic [opc_w-1:0] opc_op     = 7'b0110011;
  localparam logic [opc_w-1:0] opc_op_imm = 7'b0010011;
  localparam logic [opc_w-1:0] opc_load   = 7'b0000011;
  localparam logic [opc_w-1:0] opc_store  = 7'b0100011;
  localparam logic [opc_w-1:0] opc_branch = 7'b1100011;
  localparam logic [opc_w-1:0] opc_lui    = 7'b0110111;
  localparam logic [opc_w-1:0] opc_auipc  = 7'b0010111;
  localparam logic [opc_w-1:0] opc_jal    = 7'b1101111;
  localparam logic [opc_w-1:0] opc_jalr   = 7'b1100111;
  localparam logic [opc_w-1:0] opc_system = 7'b1110011;
  localparam logic [opc_w-1:0] opc_fence  = 7'b0001111;

  //////////////////////////////////////////////////
  // record types
  //////////////////////////////////////////////////

  typedef enum logic [3:0] {
    fmt_r,
    fmt_i,
    fmt_s,
    fmt_b,
    fmt_u,
    fmt_j,
    fmt_load,
    fmt_csr,
    fmt_sys,
    fmt_invalid
  } fmt_e;

  // one retired instruction as seen at the trace port
  typedef struct packed {
    cycle_t    cycle;
    data_t     pc;
    data_t     instr;
    fmt_e      fmt;
    reg_addr_t rd;
    logic      rd_we;
    data_t     rd_value;
    reg_addr_t rs1;
    data_t     rs1_value;
    reg_addr_t rs2;
    data_t     rs2_value;
    logic      mem_valid;
    logic      mem_we;
    data_t     mem_addr;
    data_t     mem_wdata;
  } trace_rec_t;

endpackage

`default_nettype wire

// File: issue_if.sv
`timescale 1ns/10ps
`default_nettype none

// stamp of the instruction leaving decode, valid while issue is high
interface issue_if;

  import trace_pkg::*;

  logic   issue;
  cycle_t cycle;
  data_t  pc;
  data_t  instr;
  data_t  rs1_value;
  data_t  rs2_value;

  modport src (
    output issue,
    output cycle,
    output pc,
    output instr,
    output rs1_value,
    output rs2_value
  );

  modport dst (
    input issue,
    input cycle,
    input pc,
    input instr,
    input rs1_value,
    input rs2_value
  );

endinterface

`default_nettype wire

// File: decode_if.sv
`timescale 1ns/10ps
`default_nettype none

// register usage of the word currently in decode
interface decode_if;

  import trace_pkg::*;

  fmt_e      fmt;
  reg_addr_t rd;
  logic      rd_we;
  reg_addr_t rs1;
  logic      rs1_re;
  reg_addr_t rs2;
  logic      rs2_re;
  logic      mem;

  modport src (
    output fmt,
    output rd,
    output rd_we,
    output rs1,
    output rs1_re,
    output rs2,
    output rs2_re,
    output mem
  );

  modport dst (
    input fmt,
    input rd,
    input rd_we,
    input rs1,
    input rs1_re,
    input rs2,
    input rs2_re,
    input mem
  );

endinterface

`default_nettype wire

// File: issue_stamp.sv
`timescale 1ns/10ps
`default_nettype none

module issue_stamp (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             id_valid,
  input  logic             is_decoding,
  input  logic             pipe_flush,
  input  logic             mret,
  input  logic             uret,
  input  logic             dret,
  input  logic             ecall,
  input  logic             ebreak,
  input  trace_pkg::data_t pc,
  input  trace_pkg::data_t instr,
  input  trace_pkg::data_t rs1_value,
  input  trace_pkg::data_t rs2_value,
  issue_if.src             iss
);

  import trace_pkg::*;

  cycle_t cycle_q;
  logic   leave_id;

  // free running, stamp is the value seen at the issue edge
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cycle_q <= '0;
    end else begin
      cycle_q <= cycle_q + 1'b1;
    end
  end

  // exceptions and returns leave decode without id_valid
  assign leave_id = id_valid | pipe_flush | mret | uret | ecall | ebreak | dret;

  assign iss.issue     = is_decoding & leave_id;
  assign iss.cycle     = cycle_q;
  assign iss.pc        = pc;
  assign iss.instr     = instr;
  assign iss.rs1_value = rs1_value;
  assign iss.rs2_value = rs2_value;

endmodule

`default_nettype wire

// File: trace_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module trace_decoder (
  input  trace_pkg::data_t instr,
  decode_if.src            dec
);

  import trace_pkg::*;

  logic [opc_w-1:0]    opcode;
  logic [funct3_w-1:0] funct3;
  reg_addr_t           rd_field;
  logic                writes;
  logic                reads_rs1;
  logic                reads_rs2;
  logic                accesses_mem;
  fmt_e                fmt;

  assign opcode   = instr[opcode_lsb +: opc_w];
  assign funct3   = instr[funct3_lsb +: funct3_w];
  assign rd_field = instr[rd_lsb +: reg_addr_w];

  //////////////////////////////////////////////////
  // classification by major opcode
  //////////////////////////////////////////////////

  always_comb begin
    fmt          = fmt_invalid;
    writes       = 1'b0;
    reads_rs1    = 1'b0;
    reads_rs2    = 1'b0;
    accesses_mem = 1'b0;

    case (opcode)
      opc_op: begin
        fmt       = fmt_r;
        writes    = 1'b1;
        reads_rs1 = 1'b1;
        reads_rs2 = 1'b1;
      end
      opc_op_imm, opc_jalr: begin
        fmt       = fmt_i;
        writes    = 1'b1;
        reads_rs1 = 1'b1;
      end
      opc_load: begin
        // no ld, no 64-bit unsigned forms in RV32I
        if (!(funct3 inside {3'b011, 3'b110, 3'b111})) begin
          fmt          = fmt_load;
          writes       = 1'b1;
          reads_rs1    = 1'b1;
          accesses_mem = 1'b1;
        end
      end
      opc_store: begin
        if (!funct3[2] && (funct3 != 3'b011)) begin
          fmt          = fmt_s;
          reads_rs1    = 1'b1;
          reads_rs2    = 1'b1;
          accesses_mem = 1'b1;
        end
      end
      opc_branch: begin
        fmt       = fmt_b;
        reads_rs1 = 1'b1;
        reads_rs2 = 1'b1;
      end
      opc_lui, opc_auipc: begin
        fmt    = fmt_u;
        writes = 1'b1;
      end
      opc_jal: begin
        fmt    = fmt_j;
        writes = 1'b1;
      end
      opc_system: begin
        if (funct3 != '0) begin
          fmt       = fmt_csr;
          writes    = 1'b1;
          // immediate forms carry a zimm in the rs1 slot
          reads_rs1 = ~funct3[2];
        end else begin
          fmt = fmt_sys;
        end
      end
      opc_fence: begin
        fmt = fmt_sys;
      end
      default: begin
        fmt = fmt_invalid;
      end
    endcase
  end

  assign dec.fmt    = fmt;
  assign dec.rd     = rd_field;
  assign dec.rd_we  = writes & (rd_field != '0);
  assign dec.rs1    = instr[rs1_lsb +: reg_addr_w];
  assign dec.rs1_re = reads_rs1;
  assign dec.rs2    = instr[rs2_lsb +: reg_addr_w];
  assign dec.rs2_re = reads_rs2;
  assign dec.mem    = accesses_mem;

endmodule

`default_nettype wire

// File: trace_tracker.sv
`timescale 1ns/10ps
`default_nettype none

module trace_tracker (
  input  logic                   clk,
  input  logic                   rst_n,
  issue_if.dst                   iss,
  decode_if.dst                  dec,
  input  logic                   ex_valid,
  input  logic                   ex_reg_we,
  input  logic                   ex_data_req,
  input  logic                   ex_data_gnt,
  input  logic                   ex_data_we,
  input  logic                   wb_bypass,
  input  logic                   wb_valid,
  input  logic                   wb_reg_we,
  input  trace_pkg::reg_addr_t   ex_reg_addr,
  input  trace_pkg::reg_addr_t   wb_reg_addr,
  input  trace_pkg::data_t       ex_reg_wdata,
  input  trace_pkg::data_t       ex_data_addr,
  input  trace_pkg::data_t       ex_data_wdata,
  input  trace_pkg::data_t       wb_reg_wdata,
  output logic                   trace_valid,
  output logic                   trace_overflow,
  output trace_pkg::trace_rec_t  trace_rec
);

  import trace_pkg::*;

  trace_rec_t new_rec;
  trace_rec_t ex_rec;
  trace_rec_t ex_patch;
  trace_rec_t wb_rec;
  trace_rec_t wb_patch;
  logic       ex_full;
  logic       wb_full;
  logic       ex_acc_open;
  logic       ex_acc;
  logic       ex_leave;
  logic       ex_free;
  logic       ex_take;
  logic       wb_retire;
  logic       wb_free;

  // fresh record, unused operands read as zero
  always_comb begin
    new_rec           = '0;
    new_rec.cycle     = iss.cycle;
    new_rec.pc        = iss.pc;
    new_rec.instr     = iss.instr;
    new_rec.fmt       = dec.fmt;
    new_rec.rd        = dec.rd_we ? dec.rd : '0;
    new_rec.rd_we     = dec.rd_we;
    new_rec.rs1       = dec.rs1_re ? dec.rs1 : '0;
    new_rec.rs1_value = dec.rs1_re ? iss.rs1_value : '0;
    new_rec.rs2       = dec.rs2_re ? dec.rs2 : '0;
    new_rec.rs2_value = dec.rs2_re ? iss.rs2_value : '0;
  end

  //////////////////////////////////////////////////
  // slot movement
  //////////////////////////////////////////////////

  assign wb_retire = wb_full & wb_valid;
  assign wb_free   = ~wb_full | wb_retire;
  // stalled while WB still holds an older record
  assign ex_leave  = ex_full & (ex_valid | wb_bypass) & wb_free;
  assign ex_free   = ~ex_full | ex_leave;
  assign ex_take   = iss.issue & ex_free;

  // only the first granted access of a memory instruction counts
  assign ex_acc = ex_acc_open & ex_data_req & ex_data_gnt;

  // EX patches for the current edge
  always_comb begin
    ex_patch = ex_rec;
    if (ex_reg_we && ex_rec.rd_we && (ex_reg_addr == ex_rec.rd)) begin
      ex_patch.rd_value = ex_reg_wdata;
    end
    if (ex_acc) begin
      ex_patch.mem_valid = 1'b1;
      ex_patch.mem_we    = ex_data_we;
      ex_patch.mem_addr  = ex_data_addr;
      ex_patch.mem_wdata = ex_data_we ? ex_data_wdata : '0;
    end
  end

  // WB patch
  always_comb begin
    wb_patch = wb_rec;
    if (wb_reg_we && wb_rec.rd_we && (wb_reg_addr == wb_rec.rd)) begin
      wb_patch.rd_value = wb_reg_wdata;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ex_full     <= 1'b0;
      wb_full     <= 1'b0;
      ex_acc_open <= 1'b0;
    end else begin
      if (ex_take) begin
        ex_full <= 1'b1;
      end else if (ex_leave) begin
        ex_full <= 1'b0;
      end

      if (ex_leave) begin
        wb_full <= 1'b1;
      end else if (wb_retire) begin
        wb_full <= 1'b0;
      end

      if (ex_take) begin
        ex_acc_open <= dec.mem;
      end else if (ex_leave || ex_acc) begin
        ex_acc_open <= 1'b0;
      end
    end
  end

  // slot payload
  always_ff @(posedge clk) begin
    ex_rec <= ex_take ? new_rec : ex_patch;
    wb_rec <= ex_leave ? ex_patch : wb_patch;
  end

  //////////////////////////////////////////////////
  // retire port
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      trace_valid    <= 1'b0;
      trace_overflow <= 1'b0;
      trace_rec      <= '0;
    end else begin
      trace_valid <= wb_retire;
      if (wb_retire) begin
        trace_rec <= wb_patch;
      end
      // sticky, a dropped issue is never recovered
      if (iss.issue && !ex_free) begin
        trace_overflow <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: core_tracer.sv
`timescale 1ns/10ps
`default_nettype none

module core_tracer (
  input  logic                 clk,
  input  logic                 rst_n,

  // decode stage
  input  trace_pkg::data_t     pc,
  input  trace_pkg::data_t     instr,
  input  logic                 id_valid,
  input  logic                 is_decoding,
  input  logic                 pipe_flush,
  input  logic                 mret,
  input  logic                 uret,
  input  logic                 dret,
  input  logic                 ecall,
  input  logic                 ebreak,
  input  trace_pkg::data_t     rs1_value,
  input  trace_pkg::data_t     rs2_value,

  // execute stage
  input  logic                 ex_valid,
  input  trace_pkg::reg_addr_t ex_reg_addr,
  input  logic                 ex_reg_we,
  input  trace_pkg::data_t     ex_reg_wdata,
  input  logic                 ex_data_req,
  input  logic                 ex_data_gnt,
  input  logic                 ex_data_we,
  input  trace_pkg::data_t     ex_data_addr,
  input  trace_pkg::data_t     ex_data_wdata,
  input  logic                 wb_bypass,

  // write back
  input  logic                 wb_valid,
  input  trace_pkg::reg_addr_t wb_reg_addr,
  input  logic                 wb_reg_we,
  input  trace_pkg::data_t     wb_reg_wdata,

  // trace port
  output logic                 trace_valid,
  output logic                 trace_overflow,
  output trace_pkg::cycle_t    trace_cycle,
  output trace_pkg::data_t     trace_pc,
  output trace_pkg::data_t     trace_instr,
  output trace_pkg::fmt_e      trace_fmt,
  output trace_pkg::reg_addr_t trace_rd,
  output logic                 trace_rd_we,
  output trace_pkg::data_t     trace_rd_value,
  output trace_pkg::reg_addr_t trace_rs1,
  output trace_pkg::data_t     trace_rs1_value,
  output trace_pkg::reg_addr_t trace_rs2,
  output trace_pkg::data_t     trace_rs2_value,
  output logic                 trace_mem_valid,
  output logic                 trace_mem_we,
  output trace_pkg::data_t     trace_mem_addr,
  output trace_pkg::data_t     trace_mem_wdata
);

  import trace_pkg::*;

  trace_rec_t trace_rec;

  issue_if  iss_bus ();
  decode_if dec_bus ();

  issue_stamp issue_stamp_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .id_valid    (id_valid),
    .is_decoding (is_decoding),
    .pipe_flush  (pipe_flush),
    .mret        (mret),
    .uret        (uret),
    .dret        (dret),
    .ecall       (ecall),
    .ebreak      (ebreak),
    .pc          (pc),
    .instr       (instr),
    .rs1_value   (rs1_value),
    .rs2_value   (rs2_value),
    .iss         (iss_bus.src)
  );

  trace_decoder trace_decoder_i (
    .instr (instr),
    .dec   (dec_bus.src)
  );

  trace_tracker trace_tracker_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .iss            (iss_bus.dst),
    .dec            (dec_bus.dst),
    .ex_valid       (ex_valid),
    .ex_reg_we      (ex_reg_we),
    .ex_data_req    (ex_data_req),
    .ex_data_gnt    (ex_data_gnt),
    .ex_data_we     (ex_data_we),
    .wb_bypass      (wb_bypass),
    .wb_valid       (wb_valid),
    .wb_reg_we      (wb_reg_we),
    .ex_reg_addr    (ex_reg_addr),
    .wb_reg_addr    (wb_reg_addr),
    .ex_reg_wdata   (ex_reg_wdata),
    .ex_data_addr   (ex_data_addr),
    .ex_data_wdata  (ex_data_wdata),
    .wb_reg_wdata   (wb_reg_wdata),
    .trace_valid    (trace_valid),
    .trace_overflow (trace_overflow),
    .trace_rec      (trace_rec)
  );

  // record fields out to plain ports
  assign trace_cycle     = trace_rec.cycle;
  assign trace_pc        = trace_rec.pc;
  assign trace_instr     = trace_rec.instr;
  assign trace_fmt       = trace_rec.fmt;
  assign trace_rd        = trace_rec.rd;
  assign trace_rd_we     = trace_rec.rd_we;
  assign trace_rd_value  = trace_rec.rd_value;
  assign trace_rs1       = trace_rec.rs1;
  assign trace_rs1_value = trace_rec.rs1_value;
  assign trace_rs2       = trace_rec.rs2;
  assign trace_rs2_value = trace_rec.rs2_value;
  assign trace_mem_valid = trace_rec.mem_valid;
  assign trace_mem_we    = trace_rec.mem_we;
  assign trace_mem_addr  = trace_rec.mem_addr;
  assign trace_mem_wdata = trace_rec.mem_wdata;

endmodule

`default_nettype wire

// File: tb_clock.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock (
  output logic clk,
  output logic rst_n
);

  localparam time half_period = 20ns;

  initial begin
    clk = 1'b0;
    forever #half_period clk = ~clk;
  end

  // three full cycles of reset, released on a falling edge
  initial begin
    rst_n = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

// File: tb_core_tracer.sv
`timescale 1ns/10ps
`default_nettype none

module tb_core_tracer;

  import trace_pkg::*;

  // six tests of at most about 40 cycles each, plus reset and margin
  localparam int n_tests         = 6;
  localparam int max_test_cycles = 40;
  localparam int timeout_cycles  = n_tests * max_test_cycles + 160;

  logic clk;
  logic rst_n;

  data_t     pc;
  data_t     instr;
  logic      id_valid;
  logic      is_decoding;
  logic      pipe_flush;
  logic      mret;
  logic      uret;
  logic      dret;
  logic      ecall;
  logic      ebreak;
  data_t     rs1_value;
  data_t     rs2_value;
  logic      ex_valid;
  reg_addr_t ex_reg_addr;
  logic      ex_reg_we;
  data_t     ex_reg_wdata;
  logic      ex_data_req;
  logic      ex_data_gnt;
  logic      ex_data_we;
  data_t     ex_data_addr;
  data_t     ex_data_wdata;
  logic      wb_bypass;
  logic      wb_valid;
  reg_addr_t wb_reg_addr;
  logic      wb_reg_we;
  data_t     wb_reg_wdata;

  logic      trace_valid;
  logic      trace_overflow;
  cycle_t    trace_cycle;
  data_t     trace_pc;
  data_t     trace_instr;
  fmt_e      trace_fmt;
  reg_addr_t trace_rd;
  logic      trace_rd_we;
  data_t     trace_rd_value;
  reg_addr_t trace_rs1;
  data_t     trace_rs1_value;
  reg_addr_t trace_rs2;
  data_t     trace_rs2_value;
  logic      trace_mem_valid;
  logic      trace_mem_we;
  data_t     trace_mem_addr;
  data_t     trace_mem_wdata;

  cycle_t      edge_count = '0;
  int          run_cycles = 0;
  logic [15:0] lfsr_state;
  string       test_name;
  trace_rec_t  retired[$];

  tb_clock clock_i (
    .clk   (clk),
    .rst_n (rst_n)
  );

  core_tracer dut_i (
    .clk (clk), .rst_n (rst_n),
    .pc (pc), .instr (instr), .id_valid (id_valid), .is_decoding (is_decoding),
    .pipe_flush (pipe_flush), .mret (mret), .uret (uret), .dret (dret),
    .ecall (ecall), .ebreak (ebreak), .rs1_value (rs1_value), .rs2_value (rs2_value),
    .ex_valid (ex_valid), .ex_reg_addr (ex_reg_addr), .ex_reg_we (ex_reg_we),
    .ex_reg_wdata (ex_reg_wdata), .ex_data_req (ex_data_req), .ex_data_gnt (ex_data_gnt),
    .ex_data_we (ex_data_we), .ex_data_addr (ex_data_addr),
    .ex_data_wdata (ex_data_wdata), .wb_bypass (wb_bypass),
    .wb_valid (wb_valid), .wb_reg_addr (wb_reg_addr), .wb_reg_we (wb_reg_we),
    .wb_reg_wdata (wb_reg_wdata),
    .trace_valid (trace_valid), .trace_overflow (trace_overflow),
    .trace_cycle (trace_cycle), .trace_pc (trace_pc), .trace_instr (trace_instr),
    .trace_fmt (trace_fmt), .trace_rd (trace_rd), .trace_rd_we (trace_rd_we),
    .trace_rd_value (trace_rd_value), .trace_rs1 (trace_rs1),
    .trace_rs1_value (trace_rs1_value), .trace_rs2 (trace_rs2),
    .trace_rs2_value (trace_rs2_value), .trace_mem_valid (trace_mem_valid),
    .trace_mem_we (trace_mem_we), .trace_mem_addr (trace_mem_addr),
    .trace_mem_wdata (trace_mem_wdata)
  );

  // rising edges since reset release, the expected cycle stamp
  always @(posedge clk) begin
    if (rst_n) begin
      edge_count <= edge_count + 1'b1;
    end
  end

  always @(posedge clk) begin
    run_cycles = run_cycles + 1;
    if (run_cycles > timeout_cycles) begin
      $display("run timed out after %0d cycles waiting for a retired record", run_cycles);
      abort_run();
    end
  end

  //////////////////////////////////////////////////
  // failure reporting and compares
  //////////////////////////////////////////////////

  task automatic abort_run();
    $display("Test failures found");
    $fatal(1);
  endtask

  task automatic check_word(input string field, input data_t exp, input data_t act);
    if (exp !== act) begin
      $display("ERROR %s %s: expected %h, actual %h", test_name, field, exp, act);
      abort_run();
    end
  endtask

  task automatic check_reg(input string field, input reg_addr_t exp, input reg_addr_t act);
    if (exp !== act) begin
      $display("ERROR %s %s: expected %0d, actual %0d", test_name, field, exp, act);
      abort_run();
    end
  endtask

  task automatic check_fmt(input string field, input fmt_e exp, input fmt_e act);
    if (exp !== act) begin
      $display("ERROR %s %s: expected %0d, actual %0d", test_name, field, exp, act);
      abort_run();
    end
  endtask

  task automatic check_cycle(input string field, input cycle_t exp, input cycle_t act);
    if (exp !== act) begin
      $display("ERROR %s %s: expected %0d, actual %0d", test_name, field, exp, act);
      abort_run();
    end
  endtask

  task automatic check_bit(input string field, input logic exp, input logic act);
    if (exp !== act) begin
      $display("ERROR %s %s: expected %b, actual %b", test_name, field, exp, act);
      abort_run();
    end
  endtask

  task automatic compare_rec(input trace_rec_t exp, input trace_rec_t act);
    check_cycle("cycle", exp.cycle, act.cycle);
    check_word("pc", exp.pc, act.pc);
    check_word("instr", exp.instr, act.instr);
    check_fmt("fmt", exp.fmt, act.fmt);
    check_reg("rd", exp.rd, act.rd);
    check_bit("rd_we", exp.rd_we, act.rd_we);
    check_word("rd_value", exp.rd_value, act.rd_value);
    check_reg("rs1", exp.rs1, act.rs1);
    check_word("rs1_value", exp.rs1_value, act.rs1_value);
    check_reg("rs2", exp.rs2, act.rs2);
    check_word("rs2_value", exp.rs2_value, act.rs2_value);
    check_bit("mem_valid", exp.mem_valid, act.mem_valid);
    check_bit("mem_we", exp.mem_we, act.mem_we);
    check_word("mem_addr", exp.mem_addr, act.mem_addr);
    check_word("mem_wdata", exp.mem_wdata, act.mem_wdata);
  endtask

  //////////////////////////////////////////////////
  // stimulus helpers
  //////////////////////////////////////////////////

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic [15:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 16'hB400;
    end
    return n;
  endfunction

  task automatic random_word(output data_t w);
    w = '0;
    for (int i = 0; i < xlen; i++) begin
      w = {w[xlen-2:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  function automatic data_t encode_word(input logic [6:0] hi, input reg_addr_t f_rs2,
                                        input reg_addr_t f_rs1, input logic [2:0] f3,
                                        input reg_addr_t f_rd, input logic [6:0] opc);
    return {hi, f_rs2, f_rs1, f3, f_rd, opc};
  endfunction

  function automatic trace_rec_t base_rec(input cycle_t stamp, input data_t ipc,
                                          input data_t word, input fmt_e f);
    trace_rec_t r;
    r       = '0;
    r.cycle = stamp;
    r.pc    = ipc;
    r.instr = word;
    r.fmt   = f;
    return r;
  endfunction

  // strobes last one edge, data fields keep their value
  task automatic clear_strobes();
    id_valid    = 1'b0;
    is_decoding = 1'b0;
    pipe_flush  = 1'b0;
    mret        = 1'b0;
    uret        = 1'b0;
    dret        = 1'b0;
    ecall       = 1'b0;
    ebreak      = 1'b0;
    ex_valid    = 1'b0;
    ex_reg_we   = 1'b0;
    ex_data_req = 1'b0;
    ex_data_gnt = 1'b0;
    ex_data_we  = 1'b0;
    wb_bypass   = 1'b0;
    wb_valid    = 1'b0;
    wb_reg_we   = 1'b0;
  endtask

  task automatic init_inputs();
    clear_strobes();
    pc            = '0;
    instr         = '0;
    rs1_value     = '0;
    rs2_value     = '0;
    ex_reg_addr   = '0;
    ex_reg_wdata  = '0;
    ex_data_addr  = '0;
    ex_data_wdata = '0;
    wb_reg_addr   = '0;
    wb_reg_wdata  = '0;
  endtask

  // one clock, then collect any retired record
  task automatic tick();
    trace_rec_t rec;
    @(negedge clk);
    if (trace_valid === 1'b1) begin
      rec.cycle     = trace_cycle;
      rec.pc        = trace_pc;
      rec.instr     = trace_instr;
      rec.fmt       = trace_fmt;
      rec.rd        = trace_rd;
      rec.rd_we     = trace_rd_we;
      rec.rd_value  = trace_rd_value;
      rec.rs1       = trace_rs1;
      rec.rs1_value = trace_rs1_value;
      rec.rs2       = trace_rs2;
      rec.rs2_value = trace_rs2_value;
      rec.mem_valid = trace_mem_valid;
      rec.mem_we    = trace_mem_we;
      rec.mem_addr  = trace_mem_addr;
      rec.mem_wdata = trace_mem_wdata;
      retired.push_back(rec);
    end
    clear_strobes();
  endtask

  task automatic issue_instr(input data_t ipc, input data_t word, input data_t v1,
                             input data_t v2);
    pc          = ipc;
    instr       = word;
    rs1_value   = v1;
    rs2_value   = v2;
    is_decoding = 1'b1;
    id_valid    = 1'b1;
  endtask

  task automatic wait_retire(output trace_rec_t rec);
    while (retired.size() == 0) begin
      tick();
    end
    rec = retired.pop_front();
  endtask

  task automatic expect_none(input string field);
    check_bit(field, 1'b0, retired.size() != 0);
  endtask

  //////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////

  task automatic test_add();
    data_t      v1, v2, wdata, other;
    trace_rec_t exp, got;
    test_name = "add";
    random_word(v1);
    random_word(v2);
    random_word(wdata);
    random_word(other);
    exp = base_rec(edge_count, 32'h0000_0100,
                   encode_word(7'd0, 5'd7, 5'd6, 3'b000, 5'd5, opc_op), fmt_r);
    issue_instr(exp.pc, exp.instr, v1, v2);
    tick();
    ex_valid = 1'b1;
    tick();
    wb_reg_we    = 1'b1;
    wb_reg_addr  = 5'd5;
    wb_reg_wdata = wdata;
    tick();
    expect_none("retire before wb_valid");
    // write to a different register on the retire edge
    wb_valid     = 1'b1;
    wb_reg_we    = 1'b1;
    wb_reg_addr  = 5'd9;
    wb_reg_wdata = other;
    tick();
    wait_retire(got);
    {exp.rd, exp.rd_we, exp.rd_value} = {5'd5, 1'b1, wdata};
    {exp.rs1, exp.rs1_value, exp.rs2, exp.rs2_value} = {5'd6, v1, 5'd7, v2};
    compare_rec(exp, got);
    tick();
    expect_none("single trace_valid pulse");
  endtask

  task automatic test_load();
    data_t      v1, v2, addr, junk, wdata;
    trace_rec_t exp, got;
    test_name = "lw";
    random_word(v1);
    random_word(v2);
    random_word(addr);
    random_word(junk);
    random_word(wdata);
    exp = base_rec(edge_count, 32'h0000_0104,
                   encode_word(7'd0, 5'd8, 5'd11, 3'b010, 5'd10, opc_load), fmt_load);
    issue_instr(exp.pc, exp.instr, v1, v2);
    tick();
    // granted read, write data on the bus is ignored
    {ex_data_req, ex_data_gnt, ex_data_we} = 3'b110;
    ex_data_addr  = addr;
    ex_data_wdata = junk;
    tick();
    // second grant in the same residency
    {ex_data_req, ex_data_gnt, ex_data_we} = 3'b111;
    ex_data_addr = ~addr;
    ex_valid     = 1'b1;
    tick();
    wb_valid     = 1'b1;
    wb_reg_we    = 1'b1;
    wb_reg_addr  = 5'd10;
    wb_reg_wdata = wdata;
    tick();
    wait_retire(got);
    {exp.rd, exp.rd_we, exp.rd_value} = {5'd10, 1'b1, wdata};
    exp.rs1       = 5'd11;
    exp.rs1_value = v1;
    {exp.mem_valid, exp.mem_we, exp.mem_addr, exp.mem_wdata} = {2'b10, addr, 32'd0};
    compare_rec(exp, got);
  endtask

  task automatic test_store();
    data_t      v1, v2, addr, wdata;
    trace_rec_t exp, got;
    test_name = "sw";
    random_word(v1);
    random_word(v2);
    random_word(addr);
    random_word(wdata);
    exp = base_rec(edge_count, 32'h0000_0108,
                   encode_word(7'd0, 5'd12, 5'd13, 3'b010, 5'd4, opc_store), fmt_s);
    issue_instr(exp.pc, exp.instr, v1, v2);
    tick();
    // request without grant
    ex_data_req  = 1'b1;
    ex_data_addr = ~addr;
    tick();
    {ex_data_req, ex_data_gnt, ex_data_we} = 3'b111;
    ex_data_addr  = addr;
    ex_data_wdata = wdata;
    tick();
    tick();
    expect_none("retire while EX held");
    ex_valid = 1'b1;
    tick();
    tick();
    expect_none("retire while WB held");
    wb_valid = 1'b1;
    tick();
    wait_retire(got);
    {exp.rs1, exp.rs1_value, exp.rs2, exp.rs2_value} = {5'd13, v1, 5'd12, v2};
    {exp.mem_valid, exp.mem_we, exp.mem_addr, exp.mem_wdata} = {2'b11, addr, wdata};
    compare_rec(exp, got);
  endtask

  task automatic test_branch_csr();
    data_t      v1, v2, wdata;
    trace_rec_t exp_b, exp_c, got;
    test_name = "beq/csrrwi";
    random_word(v1);
    random_word(v2);
    random_word(wdata);
    exp_b = base_rec(edge_count, 32'h0000_0200,
                     encode_word(7'd0, 5'd2, 5'd1, 3'b000, 5'd8, opc_branch), fmt_b);
    issue_instr(exp_b.pc, exp_b.instr, v1, v2);
    tick();
    // csrrwi x3, 0x300, 5 enters as the branch leaves on wb_bypass
    exp_c = base_rec(edge_count, 32'h0000_0204,
                     encode_word(7'b0011000, 5'd0, 5'd5, 3'b101, 5'd3, opc_system), fmt_csr);
    issue_instr(exp_c.pc, exp_c.instr, v2, v1);
    wb_bypass = 1'b1;
    tick();
    wb_valid = 1'b1;
    ex_valid = 1'b1;
    tick();
    wb_valid     = 1'b1;
    wb_reg_we    = 1'b1;
    wb_reg_addr  = 5'd3;
    wb_reg_wdata = wdata;
    tick();
    wait_retire(got);
    {exp_b.rs1, exp_b.rs1_value, exp_b.rs2, exp_b.rs2_value} = {5'd1, v1, 5'd2, v2};
    compare_rec(exp_b, got);
    wait_retire(got);
    {exp_c.rd, exp_c.rd_we, exp_c.rd_value} = {5'd3, 1'b1, wdata};
    compare_rec(exp_c, got);
  endtask

  task automatic test_x0_invalid();
    data_t      v1, v2;
    trace_rec_t exp_a, exp_i, exp_l, got;
    test_name = "addi-x0/invalid";
    random_word(v1);
    random_word(v2);
    exp_a = base_rec(edge_count, 32'h0000_0300,
                     encode_word(7'd0, 5'd1, 5'd1, 3'b000, 5'd0, opc_op_imm), fmt_i);
    issue_instr(exp_a.pc, exp_a.instr, v1, v2);
    tick();
    exp_i = base_rec(edge_count, 32'h0000_0304, 32'hFFFF_FFFF, fmt_invalid);
    issue_instr(exp_i.pc, exp_i.instr, v1, v2);
    ex_valid = 1'b1;
    tick();
    exp_l = base_rec(edge_count, 32'h0000_0308,
                     encode_word(7'd0, 5'd4, 5'd2, 3'b011, 5'd9, opc_load), fmt_invalid);
    issue_instr(exp_l.pc, exp_l.instr, v1, v2);
    // x0 write in WB is not a destination
    {ex_valid, wb_valid, wb_reg_we} = 3'b111;
    wb_reg_addr  = 5'd0;
    wb_reg_wdata = v2;
    tick();
    {ex_valid, wb_valid} = 2'b11;
    tick();
    wb_valid = 1'b1;
    tick();
    wait_retire(got);
    exp_a.rs1       = 5'd1;
    exp_a.rs1_value = v1;
    compare_rec(exp_a, got);
    test_name = "invalid opcode";
    wait_retire(got);
    compare_rec(exp_i, got);
    test_name = "load funct3 011";
    wait_retire(got);
    compare_rec(exp_l, got);
  endtask

  task automatic test_overflow();
    data_t      va1, va2, vb1, vb2, ra, rb;
    trace_rec_t exp_a, exp_b, got;
    test_name = "overflow";
    random_word(va1);
    random_word(va2);
    random_word(vb1);
    random_word(vb2);
    random_word(ra);
    random_word(rb);
    check_bit("overflow before", 1'b0, trace_overflow);
    exp_a = base_rec(edge_count, 32'h0000_0400,
                     encode_word(7'd0, 5'd3, 5'd2, 3'b000, 5'd1, opc_op), fmt_r);
    issue_instr(exp_a.pc, exp_a.instr, va1, va2);
    tick();
    exp_b = base_rec(edge_count, 32'h0000_0404,
                     encode_word(7'd0, 5'd6, 5'd5, 3'b000, 5'd4, opc_op), fmt_r);
    issue_instr(exp_b.pc, exp_b.instr, vb1, vb2);
    ex_valid = 1'b1;
    tick();
    // third issue, EX cannot leave because WB is held
    issue_instr(32'h0000_0408, encode_word(7'd0, 5'd9, 5'd8, 3'b000, 5'd7, opc_op),
                va2, vb2);
    ex_valid     = 1'b1;
    ex_reg_we    = 1'b1;
    ex_reg_addr  = 5'd4;
    ex_reg_wdata = rb;
    tick();
    check_bit("overflow set", 1'b1, trace_overflow);
    ex_valid = 1'b1;
    tick();
    expect_none("retire while held");
    {ex_valid, wb_valid, wb_reg_we} = 3'b111;
    wb_reg_addr  = 5'd1;
    wb_reg_wdata = ra;
    tick();
    wb_valid = 1'b1;
    tick();
    wait_retire(got);
    {exp_a.rd, exp_a.rd_we, exp_a.rd_value} = {5'd1, 1'b1, ra};
    {exp_a.rs1, exp_a.rs1_value, exp_a.rs2, exp_a.rs2_value} = {5'd2, va1, 5'd3, va2};
    compare_rec(exp_a, got);
    wait_retire(got);
    {exp_b.rd, exp_b.rd_we, exp_b.rd_value} = {5'd4, 1'b1, rb};
    {exp_b.rs1, exp_b.rs1_value, exp_b.rs2, exp_b.rs2_value} = {5'd5, vb1, 5'd6, vb2};
    compare_rec(exp_b, got);
    repeat (4) tick();
    expect_none("third record retired");
    check_bit("overflow sticky", 1'b1, trace_overflow);
  endtask

  initial begin
    lfsr_state = 16'd40042;
    init_inputs();
    wait (rst_n === 1'b1);
    tick();
    test_add();
    test_load();
    test_store();
    test_branch_csr();
    test_x0_invalid();
    test_overflow();
    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
trace_pkg.sv
issue_if.sv
decode_if.sv
issue_stamp.sv
trace_decoder.sv
trace_tracker.sv
core_tracer.sv
tb_clock.sv
tb_core_tracer.sv
